//--- list.f
hw/frontEndPkg.sv
hw/instDecode.sv
hw/ramMultiPort.sv
hw/instBuffer.sv
hw/frontEnd.sv
dv/frontEndTb.sv

//--- run.sh
#!/bin/sh
# build the front-end testbench with verilator and run it from the project root.
cd "$(dirname "$0")" &&
  verilator --binary --timescale 1ns/100ps -f list.f --top-module frontEndTb \
    -o frontEndTb &&
  ./obj_dir/frontEndTb ||
  exit 1

//--- dv/frontEndTb.sv
`timescale 1ns/100ps
`default_nettype none

module frontEndTb;

  import frontEndPkg::*;

  localparam int NUM_ROWS = 40;
  // cycle budget grows with the table length.
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 8 + 100;

  logic       clk;
  logic       rst_i;
  logic       flush;
  logic       stallDispatch;
  logic       fetchValid;
  fetchVec_t  fetchVector;
  instWord_t  fetchInst [4];
  logic       stallFetch;
  logic       dispatchReady;
  decPacket_t dispatchPacket0;
  decPacket_t dispatchPacket1;
  branchCnt_t branchCount;

  // stimulus table with one fetch group per row.
  logic       rowValid [NUM_ROWS];
  int         rowLanes [NUM_ROWS];
  instWord_t  rowWord [NUM_ROWS][4];
  logic       rowStall [NUM_ROWS];
  logic       rowFlush [NUM_ROWS];

  // reference model of the buffer contents and the group held in decode.
  decPacket_t  expQ [$];
  decPacket_t  pendQ [$];
  int          cycleCount;
  logic [31:0] lcgState;

  frontEnd u_dut (
    .clk               (clk),
    .rst_i             (rst_i),
    .flush_i           (flush),
    .stall_i           (stallDispatch),
    .fetchValid_i      (fetchValid),
    .fetchVector_i     (fetchVector),
    .fetchInst0_i      (fetchInst[0]),
    .fetchInst1_i      (fetchInst[1]),
    .fetchInst2_i      (fetchInst[2]),
    .fetchInst3_i      (fetchInst[3]),
    .stallFetch_o      (stallFetch),
    .dispatchReady_o   (dispatchReady),
    .dispatchPacket0_o (dispatchPacket0),
    .dispatchPacket1_o (dispatchPacket1),
    .branchCount_o     (branchCount)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // next state of the linear congruential generator.
  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected packet from the opcode ranges.
  function automatic decPacket_t expectPacket(input instWord_t word);
    logic [1:0] cls;
    logic       br;
    br = 1'b0;
    case (word[15:12])
      4'hC, 4'hD: begin
        cls = 2'd2;
        br = 1'b1;
      end
      // jumps are control class but no conditional branch.
      4'hE, 4'hF: cls = 2'd2;
      4'h8, 4'h9, 4'hA, 4'hB: cls = 2'd1;
      default: cls = 2'd0;
    endcase
    return {br, cls, word};
  endfunction

  function automatic int isCondBranch(input instWord_t word);
    return (word[15:12] == 4'hC || word[15:12] == 4'hD) ? 1 : 0;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      $display("** Error: %s expected %0h actual %0h", name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // random words and lane counts, then a few forced rows.
  task automatic fillTable();
    int row;
    int k;
    lcgState = 32'd16;
    for (row = 0; row < NUM_ROWS; row++) begin
      for (k = 0; k < 4; k++) begin
        lcgState = lcgNext(lcgState);
        rowWord[row][k] = lcgState[31:16];
      end
      lcgState = lcgNext(lcgState);
      rowLanes[row] = int'(lcgState[29:28]) + 1;
      rowValid[row] = (lcgState[27:25] != 3'd0);
      rowStall[row] = 1'b0;
      rowFlush[row] = 1'b0;
    end
    // every control opcode in one group.
    rowValid[4] = 1'b1;
    rowLanes[4] = 4;
    rowWord[4][0] = 16'hC123;
    rowWord[4][1] = 16'hD456;
    rowWord[4][2] = 16'hE789;
    rowWord[4][3] = 16'hFABC;
    // two conditional branches back to back.
    rowValid[5] = 1'b1;
    rowLanes[5] = 2;
    rowWord[5][0] = {4'hC, rowWord[5][0][11:0]};
    rowWord[5][1] = {4'hD, rowWord[5][1][11:0]};
    // odd groups leave single packets behind.
    rowValid[8] = 1'b1;
    rowLanes[8] = 1;
    rowValid[9] = 1'b1;
    rowLanes[9] = 3;
    // long dispatch stall with full groups fills the buffer.
    for (row = 12; row < 19; row++) begin
      rowValid[row] = 1'b1;
      rowLanes[row] = 4;
      rowStall[row] = 1'b1;
    end
    rowValid[22] = 1'b1;
    rowFlush[22] = 1'b1;
    rowValid[31] = 1'b0;
    rowFlush[31] = 1'b1;
  endtask

  // checks mid cycle, then advances the model across the next edge.
  task automatic runCycle(input string tag, output logic rowDone);
    int         count;
    int         lane;
    int         branches;
    logic       accepted;
    decPacket_t dropped;
    #4;
    count = expQ.size();
    checkValue({tag, " dispatchReady"}, 32'(count >= DISPATCH_WIDTH), 32'(dispatchReady));
    checkValue({tag, " stallFetch"}, 32'(count > STALL_LEVEL), 32'(stallFetch));
    if (count >= DISPATCH_WIDTH) begin
      branches = isCondBranch(expQ[0][15:0]) + isCondBranch(expQ[1][15:0]);
      checkValue({tag, " packet0"}, 32'(expQ[0]), 32'(dispatchPacket0));
      checkValue({tag, " packet1"}, 32'(expQ[1]), 32'(dispatchPacket1));
      checkValue({tag, " branchCount"}, 32'(branches), 32'(branchCount));
    end
    accepted = fetchValid && (count <= STALL_LEVEL);
    // flush drops the buffer, the decode register and any accept.
    if (flush) begin
      expQ.delete();
      pendQ.delete();
    end else begin
      if (count >= DISPATCH_WIDTH && !stallDispatch) begin
        dropped = expQ.pop_front();
        dropped = expQ.pop_front();
      end
      while (pendQ.size() > 0) begin
        expQ.push_back(pendQ.pop_front());
      end
      if (accepted) begin
        for (lane = 0; lane < 4; lane++) begin
          if (fetchVector[lane]) begin
            pendQ.push_back(expectPacket(fetchInst[lane]));
          end
        end
      end
    end
    rowDone = !fetchValid || flush || accepted;
    @(posedge clk);
    #1;
  endtask

  initial begin
    int   row;
    int   k;
    logic rowDone;
    rst_i = 1'b1;
    flush = 1'b0;
    stallDispatch = 1'b0;
    fetchValid = 1'b0;
    fetchVector = '0;
    for (k = 0; k < 4; k++) begin
      fetchInst[k] = '0;
    end
    fillTable();
    repeat (5) @(posedge clk);
    #1;
    rst_i = 1'b0;
    checkValue("reset stallFetch", 32'd0, 32'(stallFetch));
    checkValue("reset dispatchReady", 32'd0, 32'(dispatchReady));
    checkValue("reset branchCount", 32'd0, 32'(branchCount));
    for (row = 0; row < NUM_ROWS; row++) begin
      fetchValid = rowValid[row];
      fetchVector = fetchVec_t'((1 << rowLanes[row]) - 1);
      for (k = 0; k < 4; k++) begin
        fetchInst[k] = rowWord[row][k];
      end
      stallDispatch = rowStall[row];
      flush = rowFlush[row];
      rowDone = 1'b0;
      // group is held while fetch is stalled and dispatch runs meanwhile.
      while (!rowDone) begin
        runCycle($sformatf("row %0d", row), rowDone);
        stallDispatch = 1'b0;
        flush = 1'b0;
      end
    end
    fetchValid = 1'b0;
    while (expQ.size() >= DISPATCH_WIDTH || pendQ.size() > 0) begin
      runCycle("drain", rowDone);
    end
    runCycle("idle", rowDone);
    $display("TB PASSED");
    $finish;
  end

  initial begin
    cycleCount = 0;
    while (cycleCount <= TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TB FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

//--- hw/frontEnd.sv
`timescale 1ns/100ps
`default_nettype none

module frontEnd (
  input  wire                     clk,
  input  wire                     rst_i,
  input  wire                     flush_i,
  input  wire                     stall_i,
  input  logic                    fetchValid_i,
  input  frontEndPkg::fetchVec_t  fetchVector_i,
  input  frontEndPkg::instWord_t  fetchInst0_i,
  input  frontEndPkg::instWord_t  fetchInst1_i,
  input  frontEndPkg::instWord_t  fetchInst2_i,
  input  frontEndPkg::instWord_t  fetchInst3_i,
  output logic                    stallFetch_o,
  output logic                    dispatchReady_o,
  output frontEndPkg::decPacket_t dispatchPacket0_o,
  output frontEndPkg::decPacket_t dispatchPacket1_o,
  output frontEndPkg::branchCnt_t branchCount_o
);

  import frontEndPkg::*;

  // decode register contents on their way into the buffer.
  logic       decodeReady;
  fetchVec_t  decodedVector;
  decPacket_t decodedPacket0;
  decPacket_t decodedPacket1;
  decPacket_t decodedPacket2;
  decPacket_t decodedPacket3;

  // decode stage refuses groups while the buffer is near full.
  instDecode u_decode (
    .clk              (clk),
    .rst_i            (rst_i),
    .flush_i          (flush_i),
    .stallFetch_i     (stallFetch_o),
    .fetchValid_i     (fetchValid_i),
    .fetchVector_i    (fetchVector_i),
    .fetchInst0_i     (fetchInst0_i),
    .fetchInst1_i     (fetchInst1_i),
    .fetchInst2_i     (fetchInst2_i),
    .fetchInst3_i     (fetchInst3_i),
    .decodeReady_o    (decodeReady),
    .decodedVector_o  (decodedVector),
    .decodedPacket0_o (decodedPacket0),
    .decodedPacket1_o (decodedPacket1),
    .decodedPacket2_o (decodedPacket2),
    .decodedPacket3_o (decodedPacket3)
  );

  // queue between decode and dispatch.
  instBuffer u_instBuffer (
    .clk               (clk),
    .rst_i             (rst_i),
    .flush_i           (flush_i),
    .stall_i           (stall_i),
    .decodeReady_i     (decodeReady),
    .decodedVector_i   (decodedVector),
    .decodedPacket0_i  (decodedPacket0),
    .decodedPacket1_i  (decodedPacket1),
    .decodedPacket2_i  (decodedPacket2),
    .decodedPacket3_i  (decodedPacket3),
    .stallFetch_o      (stallFetch_o),
    .instBufferReady_o (dispatchReady_o),
    .decodedPacket0_o  (dispatchPacket0_o),
    .decodedPacket1_o  (dispatchPacket1_o),
    .branchCount_o     (branchCount_o)
  );

endmodule

`default_nettype wire

//--- hw/instBuffer.sv
`timescale 1ns/100ps
`default_nettype none

module instBuffer (
  input  wire                     clk,
  input  wire                     rst_i,
  input  wire                     flush_i,
  input  wire                     stall_i,
  input  wire                     decodeReady_i,
  input  frontEndPkg::fetchVec_t  decodedVector_i,
  input  frontEndPkg::decPacket_t decodedPacket0_i,
  input  frontEndPkg::decPacket_t decodedPacket1_i,
  input  frontEndPkg::decPacket_t decodedPacket2_i,
  input  frontEndPkg::decPacket_t decodedPacket3_i,
  output logic                    stallFetch_o,
  output logic                    instBufferReady_o,
  output frontEndPkg::decPacket_t decodedPacket0_o,
  output frontEndPkg::decPacket_t decodedPacket1_o,
  output frontEndPkg::branchCnt_t branchCount_o
);

  import frontEndPkg::*;

  // circular queue state.
  queuePtr_t headPtr;
  queuePtr_t tailPtr;
  queueCnt_t instCount;

  // per-lane write controls.
  logic      writeEnable0;
  logic      writeEnable1;
  logic      writeEnable2;
  logic      writeEnable3;
  queuePtr_t writeAddr0;
  queuePtr_t writeAddr1;
  queuePtr_t writeAddr2;
  queuePtr_t writeAddr3;
  queueCnt_t writeCount;

  // head pair read side.
  queuePtr_t readAddr0;
  queuePtr_t readAddr1;
  logic      dispatchFire;
  queueCnt_t countNext;

  // lanes land at consecutive slots from the tail.
  assign writeEnable0 = decodeReady_i & decodedVector_i[0];
  assign writeEnable1 = decodeReady_i & decodedVector_i[1];
  assign writeEnable2 = decodeReady_i & decodedVector_i[2];
  assign writeEnable3 = decodeReady_i & decodedVector_i[3];
  assign writeAddr0 = tailPtr;
  assign writeAddr1 = tailPtr + queuePtr_t'(1);
  assign writeAddr2 = tailPtr + queuePtr_t'(2);
  assign writeAddr3 = tailPtr + queuePtr_t'(3);

  // number of packets entering this cycle.
  assign writeCount = queueCnt_t'(writeEnable0) + queueCnt_t'(writeEnable1) +
                      queueCnt_t'(writeEnable2) + queueCnt_t'(writeEnable3);

  ramMultiPort u_ram (
    .clk      (clk),
    .we0_i    (writeEnable0),
    .we1_i    (writeEnable1),
    .we2_i    (writeEnable2),
    .we3_i    (writeEnable3),
    .waddr0_i (writeAddr0),
    .waddr1_i (writeAddr1),
    .waddr2_i (writeAddr2),
    .waddr3_i (writeAddr3),
    .wdata0_i (decodedPacket0_i),
    .wdata1_i (decodedPacket1_i),
    .wdata2_i (decodedPacket2_i),
    .wdata3_i (decodedPacket3_i),
    .raddr0_i (readAddr0),
    .raddr1_i (readAddr1),
    .rdata0_o (decodedPacket0_o),
    .rdata1_o (decodedPacket1_o)
  );

  // oldest packet sits at the head.
  assign readAddr0 = headPtr;
  assign readAddr1 = headPtr + queuePtr_t'(1);

  // a full pair is needed before anything leaves.
  assign instBufferReady_o = (instCount >= queueCnt_t'(DISPATCH_WIDTH));
  assign dispatchFire = instBufferReady_o & ~stall_i;

  // leaves room for the decode register plus one more group.
  assign stallFetch_o = (instCount > queueCnt_t'(STALL_LEVEL));

  // branch count only counts a valid pair.
  assign branchCount_o = instBufferReady_o ?
                         branchCnt_t'(decodedPacket0_o[PKT_BRANCH_BIT]) +
                         branchCnt_t'(decodedPacket1_o[PKT_BRANCH_BIT]) : '0;

  // old count plus arrivals, less the pair that left.
  assign countNext = instCount + writeCount -
                     (dispatchFire ? queueCnt_t'(DISPATCH_WIDTH) : '0);

  // flush wins over any write or dispatch in the same cycle.
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      headPtr   <= '0;
      tailPtr   <= '0;
      instCount <= '0;
    end else begin
      tailPtr   <= tailPtr + queuePtr_t'(writeCount);
      instCount <= countNext;
      if (dispatchFire) begin
        headPtr <= headPtr + queuePtr_t'(DISPATCH_WIDTH);
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/ramMultiPort.sv
`timescale 1ns/100ps
`default_nettype none

module ramMultiPort (
  input  wire                     clk,
  input  logic                    we0_i,
  input  logic                    we1_i,
  input  logic                    we2_i,
  input  logic                    we3_i,
  input  frontEndPkg::queuePtr_t  waddr0_i,
  input  frontEndPkg::queuePtr_t  waddr1_i,
  input  frontEndPkg::queuePtr_t  waddr2_i,
  input  frontEndPkg::queuePtr_t  waddr3_i,
  input  frontEndPkg::decPacket_t wdata0_i,
  input  frontEndPkg::decPacket_t wdata1_i,
  input  frontEndPkg::decPacket_t wdata2_i,
  input  frontEndPkg::decPacket_t wdata3_i,
  input  frontEndPkg::queuePtr_t  raddr0_i,
  input  frontEndPkg::queuePtr_t  raddr1_i,
  output frontEndPkg::decPacket_t rdata0_o,
  output frontEndPkg::decPacket_t rdata1_o
);

  import frontEndPkg::*;

  // packet storage, occupancy lives in the buffer control.
  decPacket_t mem [INST_QUEUE];

  // write ports always target distinct entries.
  always_ff @(posedge clk) begin
    if (we0_i) begin
      mem[waddr0_i] <= wdata0_i;
    end
    if (we1_i) begin
      mem[waddr1_i] <= wdata1_i;
    end
    if (we2_i) begin
      mem[waddr2_i] <= wdata2_i;
    end
    if (we3_i) begin
      mem[waddr3_i] <= wdata3_i;
    end
  end

  // asynchronous reads for the head pair.
  assign rdata0_o = mem[raddr0_i];
  assign rdata1_o = mem[raddr1_i];

endmodule

`default_nettype wire

//--- hw/instDecode.sv
`timescale 1ns/100ps
`default_nettype none

module instDecode (
  input  wire                     clk,
  input  wire                     rst_i,
  input  wire                     flush_i,
  input  wire                     stallFetch_i,
  input  logic                    fetchValid_i,
  input  frontEndPkg::fetchVec_t  fetchVector_i,
  input  frontEndPkg::instWord_t  fetchInst0_i,
  input  frontEndPkg::instWord_t  fetchInst1_i,
  input  frontEndPkg::instWord_t  fetchInst2_i,
  input  frontEndPkg::instWord_t  fetchInst3_i,
  output logic                    decodeReady_o,
  output frontEndPkg::fetchVec_t  decodedVector_o,
  output frontEndPkg::decPacket_t decodedPacket0_o,
  output frontEndPkg::decPacket_t decodedPacket1_o,
  output frontEndPkg::decPacket_t decodedPacket2_o,
  output frontEndPkg::decPacket_t decodedPacket3_o
);

  import frontEndPkg::*;

  // a group is taken only while the buffer has room for it.
  logic acceptGroup;

  // classify one word and pack it with its class and branch flag.
  function automatic decPacket_t decodeWord(input instWord_t word);
    logic [3:0] opcode;
    instType_t  instType;
    logic       isBranch;
    decPacket_t packet;
    opcode = word[OPCODE_LSB +: 4];
    // 0..7 alu, 8..b memory, c..f control.
    if (!opcode[3]) begin
      instType = INST_ALU;
    end else if (opcode[3:2] == 2'b10) begin
      instType = INST_MEM;
    end else begin
      instType = INST_CTRL;
    end
    // only c and d are conditional; e and f are jumps.
    isBranch = (opcode[3:1] == 3'b110);
    packet = '0;
    packet[PKT_BRANCH_BIT] = isBranch;
    packet[PKT_TYPE_LSB +: 2] = instType;
    packet[PKT_TYPE_LSB-1:0] = word;
    return packet;
  endfunction

  assign acceptGroup = fetchValid_i & ~stallFetch_i;

  // decode register valid, one cycle per accepted group.
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      decodeReady_o <= 1'b0;
    end else begin
      decodeReady_o <= acceptGroup;
    end
  end

  // payload is only meaningful while decodeReady_o is high.
  always_ff @(posedge clk) begin
    if (acceptGroup) begin
      decodedVector_o  <= fetchVector_i;
      decodedPacket0_o <= decodeWord(fetchInst0_i);
      decodedPacket1_o <= decodeWord(fetchInst1_i);
      decodedPacket2_o <= decodeWord(fetchInst2_i);
      decodedPacket3_o <= decodeWord(fetchInst3_i);
    end
  end

endmodule

`default_nettype wire

//--- hw/frontEndPkg.sv
`default_nettype none

package frontEndPkg;

  // instructions delivered by one fetch group.
  localparam int FETCH_WIDTH = 4;
  // packets handed to dispatch per cycle.
  localparam int DISPATCH_WIDTH = 2;
  // depth of the instruction buffer and its pointer width.
  localparam int INST_QUEUE = 16;
  localparam int INST_QUEUE_LOG = 4;
  // fetch is held off above this count, so two groups in flight still fit.
  localparam int STALL_LEVEL = INST_QUEUE - 2 * FETCH_WIDTH;

  // raw instruction word, opcode in the top nibble.
  typedef logic [15:0] instWord_t;
  localparam int OPCODE_LSB = 12;

  // instruction class.
  typedef logic [1:0] instType_t;
  localparam instType_t INST_ALU = 2'd0;
  localparam instType_t INST_MEM = 2'd1;
  localparam instType_t INST_CTRL = 2'd2;

  // decoded packet: branch flag, class, raw word.
  typedef logic [18:0] decPacket_t;
  localparam int PKT_BRANCH_BIT = 18;
  localparam int PKT_TYPE_LSB = 16;

  // lane valid vector of a fetch group.
  typedef logic [FETCH_WIDTH-1:0] fetchVec_t;
  // queue pointers wrap modulo the depth.
  typedef logic [INST_QUEUE_LOG-1:0] queuePtr_t;
  // occupancy needs one more bit to reach a full queue.
  typedef logic [INST_QUEUE_LOG:0] queueCnt_t;
  // conditional branches among a dispatch pair.
  typedef logic [1:0] branchCnt_t;

endpackage

`default_nettype wire
